/* project.f */
+incdir+rtl
+incdir+tests
rtl/bp_pkg.sv
rtl/bimodal_predictor.sv
rtl/local_predictor.sv
rtl/tournament_chooser.sv
rtl/branch_predictor_top.sv
tests/tb_branch_predictor.sv

/* rtl/bimodal_predictor.sv */
`include "bp_defines.svh"

module bimodal_predictor (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BP_PC_BITS-1:0] predict_pc,
    input  bp_pkg::bp_update_t     update,
    output logic                   predict_taken,
    output logic                   update_vote
);

    localparam int entries = 1 << `BP_INDEX_BITS;

    bp_pkg::counter_t pht [entries]; // One counter per PC index

    logic [`BP_INDEX_BITS-1:0] pred_idx;
    logic [`BP_INDEX_BITS-1:0] upd_idx;

    // Index hash is a plain low-bit slice
    assign pred_idx = predict_pc[`BP_INDEX_BITS-1:0];
    assign upd_idx  = update.pc[`BP_INDEX_BITS-1:0];

    // Both read ports see the table before this cycle's update
    assign predict_taken = pht[pred_idx][1];
    assign update_vote   = pht[upd_idx][1]; // Vote the chooser trains on

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                pht[i] <= bp_pkg::WEAK_NOT_TAKEN;
            end
        end else if (update.valid) begin
            pht[upd_idx] <= bp_pkg::counter_step(pht[upd_idx], update.taken);
        end
    end

    // An unknown update PC would corrupt an unpredictable entry
    a_update_pc_known : assert property (
        @(posedge clk) disable iff (rst)
        update.valid |-> !$isunknown(update.pc)
    ) else $error("bimodal_predictor: update.pc has unknown bits while valid");

endmodule

/* rtl/bp_defines.svh */
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Low PC bits that form the table index
// Every table has 2**BP_INDEX_BITS entries
`define BP_INDEX_BITS 3

// Local history length per entry, at least 2
// Each entry owns 2**BP_HIST_BITS pattern counters
`define BP_HIST_BITS 2

// Program counter width
`define BP_PC_BITS 32

`endif

/* rtl/bp_pkg.sv */
`include "bp_defines.svh"

package bp_pkg;

    // 2-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } counter_t;

    // Chooser counter, upper bit selects the local predictor
    typedef enum logic [1:0] {
        STRONG_BIMODAL = 2'b00,
        WEAK_BIMODAL   = 2'b01,
        WEAK_LOCAL     = 2'b10,
        STRONG_LOCAL   = 2'b11
    } chooser_t;

    // Resolved branch strobe
    typedef struct packed {
        logic                   valid; // One update per cycle
        logic [`BP_PC_BITS-1:0] pc;    // Branch address
        logic                   taken; // Resolved outcome
    } bp_update_t;

    // Component predictions handed to the chooser
    typedef struct packed {
        logic bimodal;    // PC-indexed counter vote
        logic local_vote; // Local history vote
    } bp_votes_t;

    // One saturating step toward taken or not taken
    function automatic counter_t counter_step(input counter_t c, input logic taken);
        counter_t n;
        n = c; // Hold at the rails
        if (taken && (c != STRONG_TAKEN)) begin
            n = counter_t'(c + 2'd1);
        end else if (!taken && (c != STRONG_NOT_TAKEN)) begin
            n = counter_t'(c - 2'd1);
        end
        return n;
    endfunction

endpackage

/* rtl/branch_predictor_top.sv */
`include "bp_defines.svh"

module branch_predictor_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BP_PC_BITS-1:0] predict_pc,
    input  bp_pkg::bp_update_t     update,
    output logic                   prediction
);

    bp_pkg::bp_votes_t pred_votes; // Component votes for predict_pc
    bp_pkg::bp_votes_t upd_votes;  // Component votes for update.pc, pre-update

    // PC-indexed counters
    bimodal_predictor u_bimodal (
        .clk           (clk),
        .rst           (rst),
        .predict_pc    (predict_pc),
        .update        (update),
        .predict_taken (pred_votes.bimodal),
        .update_vote   (upd_votes.bimodal)
    );

    // Per-entry history with private pattern tables
    local_predictor u_local (
        .clk           (clk),
        .rst           (rst),
        .predict_pc    (predict_pc),
        .update        (update),
        .predict_taken (pred_votes.local_vote),
        .update_vote   (upd_votes.local_vote)
    );

    // Picks a component per index and trains on disagreement
    tournament_chooser u_chooser (
        .clk        (clk),
        .rst        (rst),
        .predict_pc (predict_pc),
        .update     (update),
        .pred_votes (pred_votes),
        .upd_votes  (upd_votes),
        .prediction (prediction)
    );

endmodule

/* rtl/local_predictor.sv */
`include "bp_defines.svh"

module local_predictor (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BP_PC_BITS-1:0] predict_pc,
    input  bp_pkg::bp_update_t     update,
    output logic                   predict_taken,
    output logic                   update_vote
);

    localparam int entries  = 1 << `BP_INDEX_BITS;
    localparam int patterns = 1 << `BP_HIST_BITS;

    // Shift below needs a history of two bits or more
    if (`BP_HIST_BITS < 2) begin : g_hist_check
        $error("local_predictor: BP_HIST_BITS must be at least 2");
    end

    logic [`BP_HIST_BITS-1:0] bht [entries];           // Per-entry outcome history
    bp_pkg::counter_t         pht [entries][patterns]; // Private pattern table per entry

    logic [`BP_INDEX_BITS-1:0] pred_idx;
    logic [`BP_INDEX_BITS-1:0] upd_idx;
    logic [`BP_HIST_BITS-1:0]  pred_hist;
    logic [`BP_HIST_BITS-1:0]  upd_hist;

    assign pred_idx = predict_pc[`BP_INDEX_BITS-1:0];
    assign upd_idx  = update.pc[`BP_INDEX_BITS-1:0];

    // History picks the counter inside the entry's own table
    assign pred_hist = bht[pred_idx];
    assign upd_hist  = bht[upd_idx]; // Pre-update history

    assign predict_taken = pht[pred_idx][pred_hist][1];
    assign update_vote   = pht[upd_idx][upd_hist][1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                bht[i] <= '0;
                for (int j = 0; j < patterns; j++) begin
                    pht[i][j] <= bp_pkg::WEAK_NOT_TAKEN;
                end
            end
        end else if (update.valid) begin
            // Train the counter the old history selected
            pht[upd_idx][upd_hist] <=
                bp_pkg::counter_step(pht[upd_idx][upd_hist], update.taken);
            // Newest outcome enters at the bottom
            bht[upd_idx] <= {upd_hist[`BP_HIST_BITS-2:0], update.taken};
        end
    end

    // Every history value must land on a reset counter
    a_predict_known : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(predict_taken)
    ) else $error("local_predictor: predict_taken is unknown after reset");

endmodule

/* rtl/tournament_chooser.sv */
`include "bp_defines.svh"

module tournament_chooser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BP_PC_BITS-1:0] predict_pc,
    input  bp_pkg::bp_update_t     update,
    input  bp_pkg::bp_votes_t      pred_votes,
    input  bp_pkg::bp_votes_t      upd_votes,
    output logic                   prediction
);

    localparam int entries = 1 << `BP_INDEX_BITS;

    bp_pkg::chooser_t chooser [entries]; // One selector per PC index

    logic [`BP_INDEX_BITS-1:0] pred_idx;
    logic [`BP_INDEX_BITS-1:0] upd_idx;
    logic                      disagree;     // Components voted differently
    logic                      toward_local; // Local vote was the right one
    logic                      train;

    assign pred_idx = predict_pc[`BP_INDEX_BITS-1:0];
    assign upd_idx  = update.pc[`BP_INDEX_BITS-1:0];

    // Upper chooser bit selects the local vote
    assign prediction = chooser[pred_idx][1] ? pred_votes.local_vote : pred_votes.bimodal;

    // With disagreeing votes exactly one of them matches the outcome
    assign disagree     = upd_votes.bimodal != upd_votes.local_vote;
    assign toward_local = upd_votes.local_vote == update.taken;
    assign train        = update.valid && disagree;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                chooser[i] <= bp_pkg::WEAK_BIMODAL;
            end
        end else if (train) begin
            // Same encoding as the counters, so the counter step applies
            chooser[upd_idx] <= bp_pkg::chooser_t'(
                bp_pkg::counter_step(bp_pkg::counter_t'(chooser[upd_idx]), toward_local));
        end
    end

    // Entries outside the trained index keep their value across the edge
    for (genvar gi = 0; gi < entries; gi++) begin : g_hold_check
        a_chooser_hold : assert property (
            @(posedge clk) disable iff (rst)
            !(train && (upd_idx == gi)) |=> $stable(chooser[gi])
        ) else $error("tournament_chooser: entry %0d changed without training", gi);
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tb_branch_predictor \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Testbench reported failure"
    exit 1
fi

echo "Run finished without a failure report"
exit 0

/* tests/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int model_entries  = 1 << `BP_INDEX_BITS;
localparam int model_patterns = 1 << `BP_HIST_BITS;

// Counter encoding 0 strong not taken up to 3 strong taken
logic [1:0]               model_bim  [model_entries];                 // Bimodal counters
logic [`BP_HIST_BITS-1:0] model_hist [model_entries];                 // Local histories
logic [1:0]               model_pht  [model_entries][model_patterns]; // Local pattern counters
logic [1:0]               model_cho  [model_entries];                 // 0 strong bimodal, 3 strong local
int                       model_updates = 0;

// Saturating 2-bit step
function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
    if (up && (c != 2'd3)) begin
        return c + 2'd1;
    end
    if (!up && (c != 2'd0)) begin
        return c - 2'd1;
    end
    return c; // Pinned at a rail
endfunction

function automatic logic [`BP_INDEX_BITS-1:0] index_of(input logic [`BP_PC_BITS-1:0] pc);
    return pc[`BP_INDEX_BITS-1:0]; // Low bits only, upper PC bits alias
endfunction

// Final prediction from the current model tables
function automatic logic model_predict(input logic [`BP_PC_BITS-1:0] pc);
    logic [`BP_INDEX_BITS-1:0] idx;
    logic                      local_taken;
    logic                      bim_taken;
    idx         = index_of(pc);
    local_taken = model_pht[idx][model_hist[idx]] >= 2'd2;
    bim_taken   = model_bim[idx] >= 2'd2;
    return (model_cho[idx] >= 2'd2) ? local_taken : bim_taken;
endfunction

function automatic logic [1:0] model_bimodal_state(input logic [`BP_PC_BITS-1:0] pc);
    return model_bim[index_of(pc)];
endfunction

function automatic logic [1:0] model_chooser_state(input logic [`BP_PC_BITS-1:0] pc);
    return model_cho[index_of(pc)];
endfunction

task automatic model_reset();
    for (int i = 0; i < model_entries; i++) begin
        model_bim[i]  = 2'd1; // Weak not taken
        model_hist[i] = '0;
        model_cho[i]  = 2'd1; // Weak bimodal
        for (int j = 0; j < model_patterns; j++) begin
            model_pht[i][j] = 2'd1;
        end
    end
endtask

// One resolved branch, all three tables at once
task automatic model_update(input bp_pkg::bp_update_t u);
    logic [`BP_INDEX_BITS-1:0] idx;
    logic [`BP_HIST_BITS-1:0]  h;
    logic                      local_taken;
    logic                      bim_taken;
    if (u.valid) begin
        idx         = index_of(u.pc);
        h           = model_hist[idx]; // History before this outcome
        local_taken = model_pht[idx][h] >= 2'd2;
        bim_taken   = model_bim[idx] >= 2'd2;
        // Chooser only learns when exactly one side was right
        if (local_taken != bim_taken) begin
            model_cho[idx] = sat_step(model_cho[idx], local_taken == u.taken);
        end
        model_bim[idx]    = sat_step(model_bim[idx], u.taken);
        model_pht[idx][h] = sat_step(model_pht[idx][h], u.taken);
        model_hist[idx]   = {h[`BP_HIST_BITS-2:0], u.taken}; // Outcome enters at bit 0
        model_updates++;
    end
endtask

`endif

/* tests/tb_branch_predictor.sv */
`include "bp_defines.svh"

module tb_branch_predictor;

    logic                   clk;
    logic                   rst;
    logic [`BP_PC_BITS-1:0] predict_pc;
    bp_pkg::bp_update_t     update;
    logic                   prediction;

    int   seed     = 77;   // Random stream seed
    int   errors   = 0;
    int   timeouts = 0;
    logic exp_pred = 1'b0; // Model prediction for the current predict_pc

    `include "tb_ref_model.svh"

    branch_predictor_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .predict_pc (predict_pc),
        .update     (update),
        .prediction (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Model tables move at the same edge as the DUT tables
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_reset();
        end else begin
            model_update(update);
        end
    end

    // Mid-cycle, inputs and model state are both settled
    always @(negedge clk) begin
        exp_pred = model_predict(predict_pc);
    end

    a_prediction_matches : assert property (
        @(posedge clk) disable iff (rst)
        prediction == exp_pred
    ) else begin
        errors++;
        $display("mismatch prediction expected 0x%0h actual 0x%0h",
                 $sampled(exp_pred), $sampled(prediction));
    end

    a_prediction_known : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(prediction)
    ) else begin
        errors++;
        $display("prediction has unknown bits outside reset");
    end

    // One cycle of stimulus, applied just after the rising edge
    task automatic drive(input logic valid, input logic [`BP_PC_BITS-1:0] pc,
                         input logic taken, input logic [`BP_PC_BITS-1:0] ppc);
        bp_pkg::bp_update_t u;
        u.valid = valid;
        u.pc    = pc;
        u.taken = taken;
        @(posedge clk);
        update     <= u;
        predict_pc <= ppc;
    endtask

    task automatic idle(input logic [`BP_PC_BITS-1:0] ppc);
        drive(1'b0, '0, 1'b0, ppc);
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    initial begin
        int                     n;
        logic                   t;
        logic [31:0]            r;
        logic [31:0]            q;
        rst        = 1'b1;
        predict_pc = '0;
        update     = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Fresh tables, every index reads not taken
        for (int i = 0; i < 16; i++) begin
            idle(32'h1000 + 32'(i));
        end

        // Always taken at index 1 until the bimodal counter saturates
        n = 0;
        while ((model_bimodal_state(32'h11) != 2'd3) && (n < 20)) begin
            drive(1'b1, 32'h11, 1'b1, 32'h11);
            @(negedge clk);
            n++;
        end
        if (model_bimodal_state(32'h11) != 2'd3) report_timeout("taken saturation");
        drive(1'b1, 32'h11, 1'b0, 32'h11); // Single miss must not flip it
        repeat (3) idle(32'h11);

        // Alternating branch at index 2 until the chooser trusts local
        n = 0;
        t = 1'b1;
        while ((model_chooser_state(32'h22) < 2'd2) && (n < 100)) begin
            drive(1'b1, 32'h22, t, 32'h22);
            @(negedge clk);
            t = ~t;
            n++;
        end
        if (model_chooser_state(32'h22) < 2'd2) report_timeout("chooser toward local");
        for (int i = 0; i < 12; i++) begin
            drive(1'b1, 32'h22, t, 32'h22); // Prediction follows the pattern
            t = ~t;
        end

        // Aliasing, same index through two PCs
        repeat (4) drive(1'b1, 32'h103, 1'b1, 32'h203);
        repeat (4) drive(1'b1, 32'h203, 1'b0, 32'h103);
        idle(32'h203);

        // Update and predict of one PC in the same cycle
        repeat (3) drive(1'b1, 32'h5, 1'b1, 32'h5);
        idle(32'h5);
        drive(1'b1, 32'h5, 1'b0, 32'h5);
        idle(32'h5);

        // Random stream over a small PC range so entries collide
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            q = $random(seed);
            drive(r[0] | r[1], {24'h0, r[15:8]}, r[2], {24'h0, q[7:0]});
        end
        repeat (2) idle('0);

        $display("updates %0d errors %0d timeouts %0d", model_updates, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
